// File: Makefile
VERILATOR ?= verilator
TOP ?= bpred_tb
OBJ_DIR ?= obj_dir
FILELIST ?= tb.f
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/bpred_if.sv
`timescale 1ns/10ps

// one prediction record travelling down the pipe
interface pred_meta_if;
	logic valid;
	bpred_pkg::rv32i_word pc;
	logic [bpred_pkg::ghr_size-1:0] ghr;
	logic taken;
	bpred_pkg::rv32i_word target;
	// 1 = gshare was chosen
	logic sel;
	logic local_taken;
	logic gshare_taken;

	modport src (output valid, pc, ghr, taken, target, sel, local_taken, gshare_taken);
	modport dst (input valid, pc, ghr, taken, target, sel, local_taken, gshare_taken);
endinterface

// training request from execute back to fetch
interface pred_update_if;
	logic update;
	bpred_pkg::rv32i_word pc;
	logic [bpred_pkg::ghr_size-1:0] ghr;
	logic outcome;
	bpred_pkg::rv32i_word target;
	logic train_sel;
	logic gshare_right;

	modport src (output update, pc, ghr, outcome, target, train_sel, gshare_right);
	modport dst (input update, pc, ghr, outcome, target, train_sel, gshare_right);
endinterface

// File: logic/bpred_pkg.sv
package bpred_pkg;

	typedef logic [31:0] rv32i_word;

	// global history length, also the counter table index width
	localparam int ghr_size = 10;
	localparam int table_depth = 1024;

	// btb index is pc[7:2], tag is pc[31:8]
	localparam int btb_index_bits = 6;
	localparam int btb_depth = 2 ** btb_index_bits;
	localparam int btb_tag_bits = 32 - btb_index_bits - 2;

	// 2-bit saturating counter states
	localparam logic [1:0] ctr_strong_nt = 2'b00;
	// the selector reads this as weakly local
	localparam logic [1:0] ctr_weak_nt = 2'b01;
	localparam logic [1:0] ctr_strong_t = 2'b11;

	localparam rv32i_word reset_pc = 32'h0000_0000;

endpackage

// File: logic/bpred_top.sv
`timescale 1ns/10ps

module bpred_top (
	input logic clk,
	input logic rst_n,
	input logic load_pipeline,
	input logic stall,
	input bpred_pkg::rv32i_word fetch_pc,
	input logic ex_br,
	input logic ex_taken,
	input bpred_pkg::rv32i_word ex_target,
	output logic pred_taken,
	output bpred_pkg::rv32i_word pred_target,
	output bpred_pkg::rv32i_word ex_pc,
	output logic redirect,
	output bpred_pkg::rv32i_word redirect_pc
);

	pred_meta_if fetch_meta ();
	pred_meta_if ex_meta ();
	pred_update_if upd ();

	fetch_predictor fetch (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_pc(fetch_pc),
		.load_pipeline(load_pipeline),
		.meta(fetch_meta.src),
		.upd(upd.dst)
	);

	prediction_pipe pipe (
		.clk(clk),
		.rst_n(rst_n),
		.load_pipeline(load_pipeline),
		.stall(stall),
		.redirect(redirect),
		.in_meta(fetch_meta.dst),
		.ex_meta(ex_meta.src)
	);

	branch_resolver resolver (
		.ex_meta(ex_meta.dst),
		.ex_br(ex_br),
		.ex_taken(ex_taken),
		.ex_target(ex_target),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.upd(upd.src)
	);

	assign pred_taken = fetch_meta.taken;
	assign pred_target = fetch_meta.target;
	assign ex_pc = ex_meta.pc;

endmodule

// File: logic/branch_resolver.sv
`timescale 1ns/10ps

module branch_resolver (
	pred_meta_if.dst ex_meta,
	input logic ex_br,
	input logic ex_taken,
	input bpred_pkg::rv32i_word ex_target,
	output logic redirect,
	output bpred_pkg::rv32i_word redirect_pc,
	pred_update_if.src upd
);

	logic resolve;
	logic dir_wrong;
	logic target_wrong;

	// a real branch sitting in execute
	assign resolve = ex_meta.valid && ex_br;

	assign dir_wrong = ex_meta.taken != ex_taken;
	assign target_wrong = ex_meta.taken && ex_taken && (ex_meta.target != ex_target);

	assign redirect = resolve && (dir_wrong || target_wrong);
	assign redirect_pc = ex_taken ? ex_target : ex_meta.pc + 32'd4;

	assign upd.update = resolve;
	assign upd.pc = ex_meta.pc;
	assign upd.ghr = ex_meta.ghr;
	assign upd.outcome = ex_taken;
	assign upd.target = ex_target;

	// selector only learns when the two tables disagreed
	assign upd.train_sel = ex_meta.local_taken != ex_meta.gshare_taken;
	assign upd.gshare_right = ex_meta.gshare_taken == ex_taken;

endmodule

// File: logic/branch_target_buffer.sv
`timescale 1ns/10ps

module branch_target_buffer (
	input logic clk,
	input logic rst_n,
	input bpred_pkg::rv32i_word rpc,
	output logic hit,
	output bpred_pkg::rv32i_word rtarget,
	input logic load,
	input bpred_pkg::rv32i_word wpc,
	input bpred_pkg::rv32i_word wtarget
);

	logic valid [bpred_pkg::btb_depth];
	logic [bpred_pkg::btb_tag_bits-1:0] tags [bpred_pkg::btb_depth];
	bpred_pkg::rv32i_word targets [bpred_pkg::btb_depth];

	logic [bpred_pkg::btb_index_bits-1:0] ridx;
	logic [bpred_pkg::btb_index_bits-1:0] widx;
	logic [bpred_pkg::btb_tag_bits-1:0] rtag;

	assign ridx = rpc[bpred_pkg::btb_index_bits+1:2];
	assign rtag = rpc[31:bpred_pkg::btb_index_bits+2];
	assign widx = wpc[bpred_pkg::btb_index_bits+1:2];

	assign hit = valid[ridx] && (tags[ridx] == rtag);
	assign rtarget = targets[ridx];

	// an entry counts only while its valid bit is set
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < bpred_pkg::btb_depth; i++) begin
				valid[i] <= 1'b0;
			end
		end else if (load) begin
			valid[widx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			tags[widx] <= wpc[31:bpred_pkg::btb_index_bits+2];
			targets[widx] <= wtarget;
		end
	end

endmodule

// File: logic/counter_table.sv
`timescale 1ns/10ps

module counter_table #(
	parameter int index_bits = $clog2(bpred_pkg::table_depth)
) (
	input logic clk,
	input logic rst_n,
	input logic [index_bits-1:0] rindex,
	output logic taken,
	input logic update,
	input logic [index_bits-1:0] windex,
	input logic outcome
);

	logic [1:0] ctr [2**index_bits];

	// msb of the counter is the direction
	assign taken = ctr[rindex][1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**index_bits; i++) begin
				ctr[i] <= bpred_pkg::ctr_weak_nt;
			end
		end else if (update) begin
			// saturate at both ends
			if (outcome) begin
				if (ctr[windex] != bpred_pkg::ctr_strong_t) begin
					ctr[windex] <= ctr[windex] + 2'd1;
				end
			end else begin
				if (ctr[windex] != bpred_pkg::ctr_strong_nt) begin
					ctr[windex] <= ctr[windex] - 2'd1;
				end
			end
		end
	end

endmodule

// File: logic/fetch_predictor.sv
`timescale 1ns/10ps

module fetch_predictor (
	input logic clk,
	input logic rst_n,
	input bpred_pkg::rv32i_word fetch_pc,
	input logic load_pipeline,
	pred_meta_if.src meta,
	pred_update_if.dst upd
);

	logic [bpred_pkg::ghr_size-1:0] ghr;
	logic [bpred_pkg::ghr_size-1:0] pc_index;
	logic [bpred_pkg::ghr_size-1:0] upd_index;
	logic local_taken;
	logic gshare_taken;
	logic use_gshare;
	logic btb_hit;
	logic train;
	bpred_pkg::rv32i_word btb_target;

	assign pc_index = fetch_pc[bpred_pkg::ghr_size+1:2];
	assign upd_index = upd.pc[bpred_pkg::ghr_size+1:2];
	assign train = load_pipeline && upd.update;

	// outcome shifts in at bit 0
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ghr <= '0;
		end else if (train) begin
			ghr <= {ghr[bpred_pkg::ghr_size-2:0], upd.outcome};
		end
	end

	counter_table #(.index_bits(bpred_pkg::ghr_size)) local_table (
		.clk(clk),
		.rst_n(rst_n),
		.rindex(pc_index),
		.taken(local_taken),
		.update(train),
		.windex(upd_index),
		.outcome(upd.outcome)
	);

	// written with the history the branch was predicted with
	counter_table #(.index_bits(bpred_pkg::ghr_size)) gshare_table (
		.clk(clk),
		.rst_n(rst_n),
		.rindex(ghr ^ pc_index),
		.taken(gshare_taken),
		.update(train),
		.windex(upd.ghr ^ upd_index),
		.outcome(upd.outcome)
	);

	// msb set means trust gshare
	counter_table #(.index_bits(bpred_pkg::ghr_size)) selector_table (
		.clk(clk),
		.rst_n(rst_n),
		.rindex(pc_index),
		.taken(use_gshare),
		.update(train && upd.train_sel),
		.windex(upd_index),
		.outcome(upd.gshare_right)
	);

	branch_target_buffer btb (
		.clk(clk),
		.rst_n(rst_n),
		.rpc(fetch_pc),
		.hit(btb_hit),
		.rtarget(btb_target),
		.load(train && upd.outcome),
		.wpc(upd.pc),
		.wtarget(upd.target)
	);

	assign meta.valid = 1'b1;
	assign meta.pc = fetch_pc;
	assign meta.ghr = ghr;
	assign meta.sel = use_gshare;
	assign meta.local_taken = local_taken;
	assign meta.gshare_taken = gshare_taken;
	// taken needs a btb hit
	assign meta.taken = (use_gshare ? gshare_taken : local_taken) && btb_hit;
	assign meta.target = meta.taken ? btb_target : fetch_pc + 32'd4;

endmodule

// File: logic/prediction_pipe.sv
`timescale 1ns/10ps

module prediction_pipe (
	input logic clk,
	input logic rst_n,
	input logic load_pipeline,
	input logic stall,
	input logic redirect,
	pred_meta_if.dst in_meta,
	pred_meta_if.src ex_meta
);

	// decode stage record
	logic dec_valid;
	bpred_pkg::rv32i_word dec_pc;
	logic [bpred_pkg::ghr_size-1:0] dec_ghr;
	logic dec_taken;
	bpred_pkg::rv32i_word dec_target;
	logic dec_sel;
	logic dec_local_taken;
	logic dec_gshare_taken;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			dec_pc <= bpred_pkg::reset_pc;
			ex_meta.valid <= 1'b0;
			ex_meta.pc <= bpred_pkg::reset_pc;
		end else if (load_pipeline) begin
			if (redirect) begin
				// drop both wrong-path instructions
				dec_valid <= 1'b0;
				ex_meta.valid <= 1'b0;
			end else if (stall) begin
				// decode holds, execute gets a bubble
				ex_meta.valid <= 1'b0;
			end else begin
				dec_valid <= in_meta.valid;
				dec_pc <= in_meta.pc;
				dec_ghr <= in_meta.ghr;
				dec_taken <= in_meta.taken;
				dec_target <= in_meta.target;
				dec_sel <= in_meta.sel;
				dec_local_taken <= in_meta.local_taken;
				dec_gshare_taken <= in_meta.gshare_taken;
				ex_meta.valid <= dec_valid;
				ex_meta.pc <= dec_pc;
				ex_meta.ghr <= dec_ghr;
				ex_meta.taken <= dec_taken;
				ex_meta.target <= dec_target;
				ex_meta.sel <= dec_sel;
				ex_meta.local_taken <= dec_local_taken;
				ex_meta.gshare_taken <= dec_gshare_taken;
			end
		end
	end

endmodule

// File: tb.f
logic/bpred_pkg.sv
logic/bpred_if.sv
logic/counter_table.sv
logic/branch_target_buffer.sv
logic/fetch_predictor.sv
logic/prediction_pipe.sv
logic/branch_resolver.sv
logic/bpred_top.sv
tb/bpred_props.sv
tb/bpred_tb.sv

// File: tb/bpred_props.sv
`timescale 1ns/10ps

module bpred_props (
	input logic clk,
	input logic rst_n,
	input logic load_pipeline,
	input logic stall,
	input logic redirect,
	input logic ex_valid,
	input logic dec_valid,
	input bpred_pkg::rv32i_word dec_pc
);

	// redirect only for a real record
	redirect_needs_record: assert property (@(posedge clk) disable iff (!rst_n)
		redirect |-> ex_valid)
		else $error("redirect raised without a valid execute record");

	flush_clears_execute: assert property (@(posedge clk) disable iff (!rst_n)
		load_pipeline && redirect |=> !ex_valid)
		else $error("execute still valid after a redirect edge");

	stall_holds_decode: assert property (@(posedge clk) disable iff (!rst_n)
		load_pipeline && stall && !redirect |=> $stable(dec_valid) && $stable(dec_pc))
		else $error("decode record changed during stall");

endmodule

bind prediction_pipe bpred_props props (
	.clk(clk),
	.rst_n(rst_n),
	.load_pipeline(load_pipeline),
	.stall(stall),
	.redirect(redirect),
	.ex_valid(ex_meta.valid),
	.dec_valid(dec_valid),
	.dec_pc(dec_pc)
);

// File: tb/bpred_tb.sv
`timescale 1ns/10ps

module bpred_tb;

	logic clk = 1'b0;
	logic rst_n;
	logic load_pipeline;
	logic stall;
	bpred_pkg::rv32i_word fetch_pc;
	logic ex_br;
	logic ex_taken;
	bpred_pkg::rv32i_word ex_target;
	logic pred_taken;
	bpred_pkg::rv32i_word pred_target;
	bpred_pkg::rv32i_word ex_pc;
	logic redirect;
	bpred_pkg::rv32i_word redirect_pc;

	logic [31:0] rng = 32'd94;
	int test_errors;
	int pass_count;
	int fail_count;

	bpred_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.load_pipeline(load_pipeline),
		.stall(stall),
		.fetch_pc(fetch_pc),
		.ex_br(ex_br),
		.ex_taken(ex_taken),
		.ex_target(ex_target),
		.pred_taken(pred_taken),
		.pred_target(pred_target),
		.ex_pc(ex_pc),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error: %s is %h, expected %h", name, actual, expected);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: %0d mismatches", name, test_errors);
		end
	endtask

	// outputs sampled at the falling edge
	task automatic drive_cycle(input bpred_pkg::rv32i_word pc, input logic load,
			input logic hold, input logic br, input logic taken,
			input bpred_pkg::rv32i_word target);
		@(posedge clk);
		fetch_pc <= pc;
		load_pipeline <= load;
		stall <= hold;
		ex_br <= br;
		ex_taken <= taken;
		ex_target <= target;
		@(negedge clk);
	endtask

	task automatic reset_state_test();
		bpred_pkg::rv32i_word pc;
		test_errors = 0;
		for (int i = 0; i < 20; i++) begin
			rng = xorshift32(rng);
			pc = rng & 32'hffff_fffc;
			drive_cycle(pc, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
			check_eq("pred_taken", 32'(pred_taken), 32'd0);
			check_eq("pred_target", pred_target, pc + 32'd4);
			check_eq("redirect", 32'(redirect), 32'd0);
		end
		finish_test("reset state");
	endtask

	// cold branch at a resolves taken and trains both tables and the btb
	task automatic taken_branch_test(input bpred_pkg::rv32i_word a,
			input bpred_pkg::rv32i_word t);
		test_errors = 0;
		drive_cycle(a, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		check_eq("pred_taken", 32'(pred_taken), 32'd0);
		drive_cycle(a + 32'd4, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		drive_cycle(a + 32'd8, 1'b1, 1'b0, 1'b1, 1'b1, t);
		check_eq("ex_pc", ex_pc, a);
		check_eq("redirect", 32'(redirect), 32'd1);
		check_eq("redirect_pc", redirect_pc, t);
		drive_cycle(a, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		check_eq("pred_taken", 32'(pred_taken), 32'd1);
		check_eq("pred_target", pred_target, t);
		finish_test("taken branch");
	endtask

	task automatic not_taken_flush_test(input bpred_pkg::rv32i_word a,
			input bpred_pkg::rv32i_word t);
		test_errors = 0;
		drive_cycle(a, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		check_eq("pred_taken", 32'(pred_taken), 32'd1);
		drive_cycle(t, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		drive_cycle(t + 32'd4, 1'b1, 1'b0, 1'b1, 1'b0, t);
		check_eq("ex_pc", ex_pc, a);
		check_eq("redirect", 32'(redirect), 32'd1);
		check_eq("redirect_pc", redirect_pc, a + 32'd4);
		// both younger stages were flushed
		drive_cycle(a + 32'd4, 1'b1, 1'b0, 1'b1, 1'b1, t + 32'd8);
		check_eq("redirect", 32'(redirect), 32'd0);
		drive_cycle(a + 32'd8, 1'b1, 1'b0, 1'b1, 1'b1, t + 32'd8);
		check_eq("redirect", 32'(redirect), 32'd0);
		finish_test("not taken flush");
	endtask

	task automatic stall_bubble_test(input bpred_pkg::rv32i_word p);
		test_errors = 0;
		drive_cycle(p, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		drive_cycle(p + 32'd4, 1'b1, 1'b1, 1'b0, 1'b0, 32'd0);
		drive_cycle(p + 32'd8, 1'b1, 1'b0, 1'b1, 1'b1, 32'h0000_7000);
		check_eq("redirect", 32'(redirect), 32'd0);
		drive_cycle(p + 32'd12, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		check_eq("ex_pc", ex_pc, p);
		// p + 4 was fetched under stall and never shows up
		drive_cycle(p + 32'd16, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		check_eq("ex_pc", ex_pc, p + 32'd8);
		finish_test("stall bubble");
	endtask

	// cold branch at a, mispredicted while the pipeline is frozen
	task automatic frozen_pipeline_test(input bpred_pkg::rv32i_word a,
			input bpred_pkg::rv32i_word t);
		test_errors = 0;
		drive_cycle(a, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
		check_eq("pred_taken", 32'(pred_taken), 32'd0);
		check_eq("pred_target", pred_target, a + 32'd4);
		drive_cycle(a, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		drive_cycle(a + 32'd4, 1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
		drive_cycle(a + 32'd8, 1'b0, 1'b0, 1'b1, 1'b1, t);
		check_eq("ex_pc", ex_pc, a);
		check_eq("redirect", 32'(redirect), 32'd1);
		check_eq("redirect_pc", redirect_pc, t);
		drive_cycle(a, 1'b0, 1'b0, 1'b1, 1'b1, t);
		check_eq("redirect", 32'(redirect), 32'd1);
		drive_cycle(a, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
		check_eq("pred_taken", 32'(pred_taken), 32'd0);
		check_eq("pred_target", pred_target, a + 32'd4);
		finish_test("frozen pipeline");
	endtask

	// reset and test cycles plus margin
	initial begin
		#((10 + 20 + 4 + 5 + 5 + 6) * 10 + 300);
		$display("timeout: the tests did not finish in the expected time");
		$display("Regression failed");
		$finish;
	end

	initial begin
		rst_n <= 1'b0;
		load_pipeline <= 1'b0;
		stall <= 1'b0;
		fetch_pc <= bpred_pkg::reset_pc;
		ex_br <= 1'b0;
		ex_taken <= 1'b0;
		ex_target <= 32'd0;
		pass_count = 0;
		fail_count = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		reset_state_test();
		taken_branch_test(32'h0000_1040, 32'h0000_2000);
		not_taken_flush_test(32'h0000_1040, 32'h0000_2000);
		stall_bubble_test(32'h0000_3000);
		frozen_pipeline_test(32'h0000_5080, 32'h0000_2000);
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
